// File: design/bp_cfg_pkg.sv
/* Branch predictor sizes */
`default_nettype none

package bp_cfg_pkg;

	// PC width in bits
	parameter int ADDR_W = 32;

	// Global history length
	// Also sets the gshare index width, so the table has 2**DEF_GHR_BITS counters
	parameter int DEF_GHR_BITS = 4;

	// BTB geometry
	parameter int DEF_BTB_ROWS = 16; // Direct mapped, power of two
	parameter int DEF_TAG_BITS = 10; // PC bits above the row index

	// Branches in flight between fetch and execute
	parameter int DEF_OBQ_DEPTH = 8; // Power of two keeps the pointers simple

	// Instruction step for the fall-through PC
	parameter int INSTR_BYTES = 4;

	// Lowest PC bit used for indexing, word aligned fetch
	parameter int IDX_LSB = 2;

endpackage

`default_nettype wire

// File: design/bp_types_pkg.sv
/* Saturating counter types */
`default_nettype none

package bp_types_pkg;

	// Two-bit direction counter, MSB is the taken prediction
	typedef enum logic [1:0] {
		CTR_SNT = 2'b00, // Strong not-taken
		CTR_WNT = 2'b01, // Weak not-taken
		CTR_WT  = 2'b10, // Weak taken
		CTR_ST  = 2'b11  // Strong taken
	} ctr_t;

	// Reset state of every counter
	localparam ctr_t CTR_INIT = CTR_WNT;

	// One step towards taken, saturates at strong taken
	function automatic ctr_t ctr_inc(input ctr_t c);
		case (c)
			CTR_SNT: return CTR_WNT;
			CTR_WNT: return CTR_WT;
			default: return CTR_ST;
		endcase
	endfunction

	// One step towards not-taken, saturates at strong not-taken
	function automatic ctr_t ctr_dec(input ctr_t c);
		case (c)
			CTR_ST:  return CTR_WT;
			CTR_WT:  return CTR_WNT;
			default: return CTR_SNT;
		endcase
	endfunction

	// Predicted direction
	function automatic logic ctr_taken(input ctr_t c);
		return c[1];
	endfunction

endpackage

`default_nettype wire

// File: design/bp_if.sv
/* Lookup and resolve interfaces */
`timescale 1ns/1ps
`default_nettype none

// Fetch side lookup, answered one cycle after req
interface lookup_if #(
	parameter int GHR_BITS = bp_cfg_pkg::DEF_GHR_BITS
);
	logic                          req;    // Accepted request, already gated by ready
	logic [bp_cfg_pkg::ADDR_W-1:0] pc;
	logic                          taken;  // From gshare
	logic [bp_cfg_pkg::ADDR_W-1:0] target; // From btb, fall-through when not taken
	logic                          hit;    // From btb
	logic [GHR_BITS-1:0]           ghr;    // History used for this lookup

	// btb and gshare each drive their own share of the outputs
	modport tables (
		input  req, pc,
		output taken, target, hit, ghr
	);

	// OBQ captures the prediction
	modport queue (
		input req, taken, target, ghr
	);
endinterface

// Execute side resolve, in program order
interface resolve_if #(
	parameter int GHR_BITS = bp_cfg_pkg::DEF_GHR_BITS
);
	logic                          valid;      // Single cycle strobe
	logic [bp_cfg_pkg::ADDR_W-1:0] pc;
	logic                          taken;      // Actual direction
	logic [bp_cfg_pkg::ADDR_W-1:0] target;     // Actual target
	logic [GHR_BITS-1:0]           ghr_snap;   // Head row history
	logic                          pred_taken; // Head row direction
	logic                          mispredict; // Same cycle as valid

	modport source (
		input  valid, pc, taken, target,
		output ghr_snap, pred_taken, mispredict
	);

	modport sink (
		input valid, pc, taken, target, ghr_snap, mispredict
	);
endinterface

`default_nettype wire

// File: design/btb.sv
/* Branch target buffer */
`timescale 1ns/1ps
`default_nettype none

module btb #(
	parameter int BTB_ROWS = bp_cfg_pkg::DEF_BTB_ROWS,
	parameter int TAG_BITS = bp_cfg_pkg::DEF_TAG_BITS
) (
	input wire        clock,
	input wire        arst_n,
	lookup_if.tables  look,
	resolve_if.sink   res
);

	localparam int ADDR_W  = bp_cfg_pkg::ADDR_W;
	localparam int IDX_W   = $clog2(BTB_ROWS);
	localparam int IDX_LSB = bp_cfg_pkg::IDX_LSB;
	localparam int TAG_LSB = IDX_LSB + IDX_W; // Tag sits right above the index

	localparam logic [ADDR_W-1:0] PC_STEP = bp_cfg_pkg::INSTR_BYTES;

	// Row storage
	logic [BTB_ROWS-1:0] row_valid;           // Only the valid bits are reset
	logic [TAG_BITS-1:0] row_tag [BTB_ROWS];
	logic [ADDR_W-1:0]   row_target [BTB_ROWS];

	// Index and tag for both ports
	logic [IDX_W-1:0]    look_idx;
	logic [TAG_BITS-1:0] look_tag;
	logic [IDX_W-1:0]    res_idx;
	logic [TAG_BITS-1:0] res_tag;
	logic                look_match;

	// Lookup result of the previous cycle
	logic              hit_q;
	logic [ADDR_W-1:0] tgt_q;
	logic [ADDR_W-1:0] pc_q;  // For the fall-through

	assign look_idx = look.pc[IDX_LSB +: IDX_W];
	assign look_tag = look.pc[TAG_LSB +: TAG_BITS];
	assign res_idx  = res.pc[IDX_LSB +: IDX_W];
	assign res_tag  = res.pc[TAG_LSB +: TAG_BITS];

	// Reads the old row when a resolve writes in the same cycle
	assign look_match = row_valid[look_idx] && (row_tag[look_idx] == look_tag);

	// Control state
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			row_valid <= '0; // All entries invalid
			hit_q     <= 1'b0;
		end else begin
			hit_q <= look.req && look_match; // Pulse per request
			if (res.valid && res.taken)
				row_valid[res_idx] <= 1'b1;
		end
	end

	// Lookup payload, captured only for accepted requests
	always_ff @(posedge clock) begin
		if (look.req) begin
			tgt_q <= row_target[look_idx];
			pc_q  <= look.pc;
		end
	end

	// Allocate or refresh on taken resolves
	// Not-taken resolves leave the row alone
	always_ff @(posedge clock) begin
		if (res.valid && res.taken) begin
			row_tag[res_idx]    <= res_tag;
			row_target[res_idx] <= res.target;
		end
	end

	assign look.hit = hit_q;

	// Redirect target only if gshare also says taken
	assign look.target = (hit_q && look.taken) ? tgt_q : pc_q + PC_STEP;

endmodule

`default_nettype wire

// File: design/gshare.sv
/* Gshare direction predictor */
`timescale 1ns/1ps
`default_nettype none

module gshare #(
	parameter int GHR_BITS = bp_cfg_pkg::DEF_GHR_BITS
) (
	input wire        clock,
	input wire        arst_n,
	lookup_if.tables  look,
	resolve_if.sink   res
);

	localparam int ROWS    = 2 ** GHR_BITS; // One counter per index value
	localparam int IDX_LSB = bp_cfg_pkg::IDX_LSB;

	// Pattern table
	bp_types_pkg::ctr_t pht [ROWS];

	// Speculative history, shifted at lookup time
	logic [GHR_BITS-1:0] ghr;

	logic [GHR_BITS-1:0] look_idx;
	logic [GHR_BITS-1:0] res_idx;
	logic                look_dir;  // Prediction for the current request
	logic                taken_q;
	logic [GHR_BITS-1:0] ghr_used; // History before the shift

	// PC hashed with history
	assign look_idx = look.pc[IDX_LSB +: GHR_BITS] ^ ghr;

	// Training uses the history the branch was predicted with
	assign res_idx = res.pc[IDX_LSB +: GHR_BITS] ^ res.ghr_snap;

	assign look_dir = bp_types_pkg::ctr_taken(pht[look_idx]);

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < ROWS; i++) begin
				pht[i] <= bp_types_pkg::CTR_INIT;
			end
			ghr     <= '0;
			taken_q <= 1'b0;
		end else begin
			// Counter moves towards the actual outcome
			if (res.valid) begin
				pht[res_idx] <= res.taken ? bp_types_pkg::ctr_inc(pht[res_idx])
				                          : bp_types_pkg::ctr_dec(pht[res_idx]);
			end

			// Recovery wins over a same cycle lookup, which is on the wrong path
			if (res.mispredict)
				ghr <= {res.ghr_snap[GHR_BITS-2:0], res.taken}; // Snapshot plus actual
			else if (look.req)
				ghr <= {ghr[GHR_BITS-2:0], look_dir}; // Speculative shift

			taken_q <= look.req && look_dir; // Only high for a real request
		end
	end

	// Snapshot of the history that formed the index
	always_ff @(posedge clock) begin
		if (look.req)
			ghr_used <= ghr;
	end

	assign look.taken = taken_q;
	assign look.ghr   = ghr_used;

endmodule

`default_nettype wire

// File: design/obq.sv
/* Outstanding branch queue */
`timescale 1ns/1ps
`default_nettype none

module obq #(
	parameter int OBQ_DEPTH = bp_cfg_pkg::DEF_OBQ_DEPTH,
	parameter int GHR_BITS  = bp_cfg_pkg::DEF_GHR_BITS
) (
	input wire         clock,
	input wire         arst_n,
	lookup_if.queue    look,
	resolve_if.source  res,
	output logic       ready,
	output logic       pred_valid,
	output logic       mispredict,  // Registered pulse
	output logic [bp_cfg_pkg::ADDR_W-1:0] redirect_pc
);

	localparam int ADDR_W = bp_cfg_pkg::ADDR_W;
	localparam int PTR_W  = (OBQ_DEPTH > 1) ? $clog2(OBQ_DEPTH) : 1;
	localparam int CNT_W  = $clog2(OBQ_DEPTH + 1);

	localparam logic [ADDR_W-1:0] PC_STEP = bp_cfg_pkg::INSTR_BYTES;

	// Row fields
	logic [GHR_BITS-1:0] snap_mem   [OBQ_DEPTH];
	logic                taken_mem  [OBQ_DEPTH];
	logic [ADDR_W-1:0]   target_mem [OBQ_DEPTH];

	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] tail;
	logic [PTR_W-1:0] pend_ptr;  // Slot waiting for its prediction
	logic [CNT_W-1:0] count;     // Allocated rows, pending one included
	logic             push;
	logic             bypass;
	logic             mis;
	logic [ADDR_W-1:0] head_target;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(OBQ_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign ready = (count != CNT_W'(OBQ_DEPTH)); // Full blocks fetch

	// Slot allocated at accept, filled one cycle later when the tables answer
	// A resolve in that cycle reads the live prediction instead
	assign bypass = pred_valid && (pend_ptr == head);

	assign res.ghr_snap   = bypass ? look.ghr    : snap_mem[head];
	assign res.pred_taken = bypass ? look.taken  : taken_mem[head];
	assign head_target    = bypass ? look.target : target_mem[head];

	// Wrong direction, or right direction but wrong taken target
	assign mis = res.valid && ((res.pred_taken != res.taken) ||
	                           (res.taken && (head_target != res.target)));
	assign res.mispredict = mis;

	// Request next to a flushing resolve is younger, so it is dropped
	assign push = look.req && !mis;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			head       <= '0;
			tail       <= '0;
			pend_ptr   <= '0;
			count      <= '0;
			pred_valid <= 1'b0;
			mispredict <= 1'b0;
		end else begin
			pred_valid <= push;
			mispredict <= mis;
			if (push)
				pend_ptr <= tail;
			if (mis) begin
				// Everything left is younger than the resolved branch
				head  <= '0;
				tail  <= '0;
				count <= '0;
			end else begin
				if (push)
					tail <= ptr_next(tail);
				if (res.valid)
					head <= ptr_next(head); // In order pop
				case ({push, res.valid})
					2'b10:   count <= count + 1'b1;
					2'b01:   count <= count - 1'b1;
					default: count <= count;
				endcase
			end
		end
	end

	// Row fill, one cycle after the accept
	always_ff @(posedge clock) begin
		if (pred_valid) begin
			snap_mem[pend_ptr]   <= look.ghr;
			taken_mem[pend_ptr]  <= look.taken;
			target_mem[pend_ptr] <= look.target;
		end
	end

	// Correct path after a mispredict
	always_ff @(posedge clock) begin
		if (mis)
			redirect_pc <= res.taken ? res.target : res.pc + PC_STEP;
	end

endmodule

`default_nettype wire

// File: design/branch_predictor.sv
/* Branch predictor top */
`timescale 1ns/1ps
`default_nettype none

module branch_predictor #(
	parameter int GHR_BITS  = bp_cfg_pkg::DEF_GHR_BITS,
	parameter int BTB_ROWS  = bp_cfg_pkg::DEF_BTB_ROWS,
	parameter int TAG_BITS  = bp_cfg_pkg::DEF_TAG_BITS,
	parameter int OBQ_DEPTH = bp_cfg_pkg::DEF_OBQ_DEPTH
) (
	input wire                           clock,
	input wire                           arst_n,
	// Fetch request
	input wire                           fetch_valid,
	input wire  [bp_cfg_pkg::ADDR_W-1:0] fetch_pc,
	output logic                         fetch_ready,
	// Prediction, one cycle after accept
	output logic                         pred_valid,
	output logic                         pred_taken,
	output logic                         pred_hit,
	output logic [bp_cfg_pkg::ADDR_W-1:0] pred_target,
	// Resolved branch from execute
	input wire                           ex_valid,
	input wire  [bp_cfg_pkg::ADDR_W-1:0] ex_pc,
	input wire                           ex_taken,
	input wire  [bp_cfg_pkg::ADDR_W-1:0] ex_target,
	// Redirect, one cycle after resolve
	output logic                         mispredict,
	output logic [bp_cfg_pkg::ADDR_W-1:0] redirect_pc
);

	lookup_if  #(.GHR_BITS(GHR_BITS)) look_bus ();
	resolve_if #(.GHR_BITS(GHR_BITS)) res_bus ();

	// Only accepted requests reach the tables
	assign look_bus.req = fetch_valid && fetch_ready;
	assign look_bus.pc  = fetch_pc;

	assign res_bus.valid  = ex_valid;
	assign res_bus.pc     = ex_pc;
	assign res_bus.taken  = ex_taken;
	assign res_bus.target = ex_target;

	btb #(
		.BTB_ROWS (BTB_ROWS),
		.TAG_BITS (TAG_BITS)
	) i_btb (
		.clock  (clock),
		.arst_n (arst_n),
		.look   (look_bus.tables),
		.res    (res_bus.sink)
	);

	gshare #(
		.GHR_BITS (GHR_BITS)
	) i_gshare (
		.clock  (clock),
		.arst_n (arst_n),
		.look   (look_bus.tables),
		.res    (res_bus.sink)
	);

	obq #(
		.OBQ_DEPTH (OBQ_DEPTH),
		.GHR_BITS  (GHR_BITS)
	) i_obq (
		.clock       (clock),
		.arst_n      (arst_n),
		.look        (look_bus.queue),
		.res         (res_bus.source),
		.ready       (fetch_ready),  // Back-pressure when full
		.pred_valid  (pred_valid),
		.mispredict  (mispredict),
		.redirect_pc (redirect_pc)
	);

	// Prediction fields straight from the tables
	assign pred_taken  = look_bus.taken;
	assign pred_hit    = look_bus.hit;
	assign pred_target = look_bus.target;

endmodule

`default_nettype wire

// File: test/bp_ref_model.svh
/* Reference branch predictor model */
`ifndef BP_REF_MODEL_SVH
`define BP_REF_MODEL_SVH

localparam int BIDX_W = $clog2(BTB_ROWS);

// One branch in flight, as fetch saw it
typedef struct packed {
	logic [ADDR_W-1:0]   pc;
	logic [GHR_BITS-1:0] snap;   // History before the shift
	logic                taken;
	logic [ADDR_W-1:0]   target;
} flight_t;

bp_types_pkg::ctr_t  ref_pht [2**GHR_BITS];
logic [GHR_BITS-1:0] ref_ghr;
logic                ref_valid [BTB_ROWS];
logic [TAG_BITS-1:0] ref_tag [BTB_ROWS];
logic [ADDR_W-1:0]   ref_target [BTB_ROWS];
flight_t             in_flight [$]; // Oldest first

task automatic reset_model();
	for (int i = 0; i < 2**GHR_BITS; i++)
		ref_pht[i] = bp_types_pkg::CTR_INIT;
	for (int i = 0; i < BTB_ROWS; i++)
		ref_valid[i] = 1'b0;
	ref_ghr = '0;
	in_flight.delete();
endtask

// Saturating two-bit step
function automatic bp_types_pkg::ctr_t step_counter(input bp_types_pkg::ctr_t c,
		input logic taken);
	logic [1:0] v;
	v = c;
	if (taken && v != 2'd3)
		v = v + 2'd1;
	else if (!taken && v != 2'd0)
		v = v - 2'd1;
	return bp_types_pkg::ctr_t'(v);
endfunction

task automatic predict(input logic [ADDR_W-1:0] pc, output logic taken, output logic hit,
		output logic [ADDR_W-1:0] target);
	logic [GHR_BITS-1:0] gidx;
	logic [BIDX_W-1:0]   bidx;
	gidx   = pc[2 +: GHR_BITS] ^ ref_ghr;
	bidx   = pc[2 +: BIDX_W];
	taken  = (ref_pht[gidx] == bp_types_pkg::CTR_WT) || (ref_pht[gidx] == bp_types_pkg::CTR_ST);
	hit    = ref_valid[bidx] && (ref_tag[bidx] == pc[2 + BIDX_W +: TAG_BITS]);
	target = (hit && taken) ? ref_target[bidx] : pc + 32'd4; // Fall-through otherwise
endtask

// Resolve time update, counter indexed with the snapshot
task automatic train(input logic [ADDR_W-1:0] pc, input logic [GHR_BITS-1:0] snap,
		input logic taken, input logic [ADDR_W-1:0] target);
	logic [GHR_BITS-1:0] gidx;
	logic [BIDX_W-1:0]   bidx;
	gidx          = pc[2 +: GHR_BITS] ^ snap;
	bidx          = pc[2 +: BIDX_W];
	ref_pht[gidx] = step_counter(ref_pht[gidx], taken);
	if (taken) begin // Not-taken leaves the BTB alone
		ref_valid[bidx]  = 1'b1;
		ref_tag[bidx]    = pc[2 + BIDX_W +: TAG_BITS];
		ref_target[bidx] = target;
	end
endtask

`endif

// File: test/tb_branch_predictor.sv
/* Branch predictor testbench */
`timescale 1ns/1ps
`default_nettype none

module tb_branch_predictor;

	localparam int ADDR_W      = bp_cfg_pkg::ADDR_W;
	localparam int GHR_BITS    = bp_cfg_pkg::DEF_GHR_BITS;
	localparam int BTB_ROWS    = bp_cfg_pkg::DEF_BTB_ROWS;
	localparam int TAG_BITS    = bp_cfg_pkg::DEF_TAG_BITS;
	localparam int OBQ_DEPTH   = bp_cfg_pkg::DEF_OBQ_DEPTH;
	localparam int RAND_CYCLES = 300;
	localparam int WATCHDOG_NS = (4 + 120 + RAND_CYCLES) * 10 + 200; // Reset, directed, random

	localparam logic [ADDR_W-1:0] PC_B  = 32'h0000_1a40; // Trained taken
	localparam logic [ADDR_W-1:0] TGT_B = 32'h0000_4000;
	localparam logic [ADDR_W-1:0] PC_C  = 32'h0000_2c88; // Alternating
	localparam logic [ADDR_W-1:0] TGT_C = 32'h0000_5100;

	logic              clock, arst_n;
	logic              fetch_valid, fetch_ready, ex_valid, ex_taken;
	logic [ADDR_W-1:0] fetch_pc, ex_pc, ex_target;
	logic              pred_valid, pred_taken, pred_hit, mispredict;
	logic [ADDR_W-1:0] pred_target, redirect_pc;

	// Expected values for the cycle being driven
	logic              exp_ready, exp_pvalid, exp_taken, exp_hit, exp_mis;
	logic [ADDR_W-1:0] exp_target, exp_redirect;
	// Same values one edge later, lined up with the registered outputs
	logic              chk_pvalid, chk_taken, chk_hit, chk_mis;
	logic [ADDR_W-1:0] chk_target, chk_redirect;

	`include "bp_ref_model.svh"

	branch_predictor i_dut (
		.clock       (clock),
		.arst_n      (arst_n),
		.fetch_valid (fetch_valid),
		.fetch_pc    (fetch_pc),
		.fetch_ready (fetch_ready),
		.pred_valid  (pred_valid),
		.pred_taken  (pred_taken),
		.pred_hit    (pred_hit),
		.pred_target (pred_target),
		.ex_valid    (ex_valid),
		.ex_pc       (ex_pc),
		.ex_taken    (ex_taken),
		.ex_target   (ex_target),
		.mispredict  (mispredict),
		.redirect_pc (redirect_pc)
	);

	initial clock = 1'b0;
	always #5 clock = ~clock;

	always @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			chk_pvalid <= 1'b0;
			chk_mis    <= 1'b0;
		end else begin
			chk_pvalid   <= exp_pvalid;
			chk_taken    <= exp_taken;
			chk_hit      <= exp_hit;
			chk_target   <= exp_target;
			chk_mis      <= exp_mis;
			chk_redirect <= exp_redirect;
		end
	end

	task automatic report_mismatch(input string name, input logic [ADDR_W-1:0] expected,
			input logic [ADDR_W-1:0] actual);
		$display("ERROR: %s expected 0x%h, got 0x%h", name, expected, actual);
		$display("*** FAILED ***");
		$fatal(1, "Output mismatch");
	endtask

	// Back-pressure every cycle, prediction and redirect one cycle after the event
	a_ready: assert property (@(posedge clock) disable iff (!arst_n) fetch_ready == exp_ready)
		else report_mismatch("fetch_ready", $sampled(exp_ready), $sampled(fetch_ready));
	a_pvalid: assert property (@(posedge clock) disable iff (!arst_n) pred_valid == chk_pvalid)
		else report_mismatch("pred_valid", $sampled(chk_pvalid), $sampled(pred_valid));
	a_taken: assert property (@(posedge clock) disable iff (!arst_n)
		chk_pvalid |-> pred_taken == chk_taken)
		else report_mismatch("pred_taken", $sampled(chk_taken), $sampled(pred_taken));
	a_hit: assert property (@(posedge clock) disable iff (!arst_n)
		chk_pvalid |-> pred_hit == chk_hit)
		else report_mismatch("pred_hit", $sampled(chk_hit), $sampled(pred_hit));
	a_target: assert property (@(posedge clock) disable iff (!arst_n)
		chk_pvalid |-> pred_target == chk_target)
		else report_mismatch("pred_target", $sampled(chk_target), $sampled(pred_target));
	a_mis: assert property (@(posedge clock) disable iff (!arst_n) mispredict == chk_mis)
		else report_mismatch("mispredict", $sampled(chk_mis), $sampled(mispredict));
	a_redirect: assert property (@(posedge clock) disable iff (!arst_n)
		chk_mis |-> redirect_pc == chk_redirect)
		else report_mismatch("redirect_pc", $sampled(chk_redirect), $sampled(redirect_pc));

	// One cycle of stimulus, model stepped alongside
	task automatic run_cycle(input logic fv, input logic [ADDR_W-1:0] pc, input logic ev,
			input logic taken, input logic [ADDR_W-1:0] target);
		flight_t           head;
		logic              resolve_now, accept, p_taken, p_hit;
		logic [ADDR_W-1:0] p_target;
		@(posedge clock);
		#1;
		resolve_now = ev && (in_flight.size() != 0); // Only branches in flight resolve
		exp_ready   = in_flight.size() < OBQ_DEPTH;
		accept      = fv && exp_ready;
		predict(pc, p_taken, p_hit, p_target); // Old tables, before any update
		exp_mis     = 1'b0;
		ex_pc       = '0;
		if (resolve_now) begin
			head         = in_flight.pop_front();
			ex_pc        = head.pc;
			exp_mis      = (head.taken != taken) || (taken && head.target != target);
			exp_redirect = taken ? target : head.pc + 32'd4;
			train(head.pc, head.snap, taken, target);
		end
		exp_pvalid = accept && !exp_mis; // Younger request dropped by the flush
		exp_taken  = p_taken;
		exp_hit    = p_hit;
		exp_target = p_target;
		if (exp_mis) begin
			in_flight.delete();
			ref_ghr = {head.snap[GHR_BITS-2:0], taken}; // Recovered history
		end else if (accept) begin
			in_flight.push_back('{pc, ref_ghr, p_taken, p_target});
			ref_ghr = {ref_ghr[GHR_BITS-2:0], p_taken};
		end
		fetch_valid = fv;
		fetch_pc    = pc;
		ex_valid    = resolve_now;
		ex_taken    = taken;
		ex_target   = target;
	endtask

	task automatic request(input logic [ADDR_W-1:0] pc);
		run_cycle(1'b1, pc, 1'b0, 1'b0, '0);
	endtask

	task automatic resolve(input logic taken, input logic [ADDR_W-1:0] target);
		run_cycle(1'b0, '0, 1'b1, taken, target);
	endtask

	function automatic logic [ADDR_W-1:0] random_pc();
		return ADDR_W'(32'h0000_3000 + ($urandom_range(31, 0) << 2)); // Shared rows, mixed tags
	endfunction

	function automatic logic [ADDR_W-1:0] random_target();
		return ADDR_W'(32'h0000_6000 + ($urandom_range(7, 0) << 4));
	endfunction

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the stimulus did not finish within %0d ns", WATCHDOG_NS);
		$display("*** FAILED ***");
		$fatal(1, "Watchdog expired");
	end

	initial begin
		logic              fv, ev, tk;
		logic [ADDR_W-1:0] tg;
		void'($urandom(45706));
		arst_n      = 1'b0;
		fetch_valid = 1'b0;
		fetch_pc    = '0;
		ex_valid    = 1'b0;
		ex_pc       = '0;
		ex_taken    = 1'b0;
		ex_target   = '0;
		exp_ready   = 1'b1;
		exp_pvalid  = 1'b0;
		exp_mis     = 1'b0;
		reset_model();
		repeat (4) @(posedge clock);
		#1 arst_n = 1'b1;

		request(random_pc()); // Cold lookup, not-taken fall-through
		resolve(1'b0, '0);
		for (int k = 0; k < 8; k++) begin // History saturates, then counter trains
			request(PC_B);
			resolve(1'b1, TGT_B);
		end
		request(PC_B); // Wrong taken target
		resolve(1'b1, TGT_B + 32'h10);
		request(PC_B); // Wrong direction
		resolve(1'b0, '0);

		repeat (OBQ_DEPTH + 2) request(random_pc()); // Fill, then held off
		run_cycle(1'b1, random_pc(), 1'b1, in_flight[0].taken, in_flight[0].target);
		resolve(!in_flight[0].taken, random_target()); // Flush
		repeat (OBQ_DEPTH + 1) request(random_pc());
		while (in_flight.size() != 0)
			resolve(1'($urandom_range(1, 0)), random_target());

		for (int k = 0; k < 24; k++) begin
			request(PC_C);
			resolve(1'(k % 2), TGT_C);
		end

		repeat (RAND_CYCLES) begin
			fv = 1'($urandom_range(1, 0));
			ev = (in_flight.size() != 0) && ($urandom_range(2, 0) == 0);
			tk = 1'($urandom_range(1, 0));
			tg = random_target();
			if (ev && $urandom_range(1, 0) == 1) begin // Half the resolves agree
				tk = in_flight[0].taken;
				tg = in_flight[0].target;
			end
			run_cycle(fv, random_pc(), ev, tk, tg);
		end
		run_cycle(1'b0, '0, 1'b0, 1'b0, '0);
		run_cycle(1'b0, '0, 1'b0, 1'b0, '0); // Last outputs checked

		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+test
design/bp_cfg_pkg.sv
design/bp_types_pkg.sv
design/bp_if.sv
design/btb.sv
design/gshare.sv
design/obq.sv
design/branch_predictor.sv
test/tb_branch_predictor.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_branch_predictor
FILELIST  := sim.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
